//--- source/fetch_settings.svh
////////////////////////////////////////////////////////////
// Fetch front end settings
// Widths, memory size and pipeline timing constants
////////////////////////////////////////////////////////////
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction and PC width
`define FETCH_WIDTH 16

// Instruction memory size in words
`define IMEM_DEPTH 256

// Cycles a reported destination register blocks readers
`define HAZARD_WINDOW 3

// Cycles from halt leaving the issue buffer to dump
`define HALT_DELAY 5

// Bubble instruction
`define NOP_WORD 16'h0800

`endif

//--- source/fetch_pkg.sv
////////////////////////////////////////////////////////////
// Fetch front end types
// Instruction, address and fetch item types, opcode decode
////////////////////////////////////////////////////////////
`default_nettype none
`include "fetch_settings.svh"

package fetch_pkg;

   typedef logic [`FETCH_WIDTH-1:0] instr_t;
   typedef logic [`FETCH_WIDTH-1:0] pc_t;
   typedef logic [2:0]              reg_idx_t;

   // Instruction plus its own PC + 2
   typedef struct packed {
      instr_t instr;
      pc_t    incr_pc;
   } fetch_item_t;

   typedef enum logic [1:0] {op_halt, op_jump, op_other} op_class_t;

   // rs is a real source except for 000xx and 001x0
   function automatic logic uses_rs(input logic [4:0] opcode);
      return (opcode[4:2] != 3'b000) && ({opcode[4:2], opcode[0]} != 4'b0010);
   endfunction

   // rt only read by 1101x and 111xx
   function automatic logic uses_rt(input logic [4:0] opcode);
      return (opcode[4:1] == 4'b1101) || (opcode[4:2] == 3'b111);
   endfunction

endpackage

`default_nettype wire

//--- source/fetch_if.sv
////////////////////////////////////////////////////////////
// Fetch front end interfaces
// Memory read port and fetch to issue buffer handshake
////////////////////////////////////////////////////////////
`default_nettype none

// Synchronous read port, data one cycle after rd_en
interface imem_rd_if;
   logic              rd_en;
   fetch_pkg::pc_t    rd_addr;
   fetch_pkg::instr_t rd_data;
   // Registered rd_en, marks fresh rd_data
   logic              rd_hit;

   modport master (output rd_en, output rd_addr, input rd_data, input rd_hit);
   modport memory (input rd_en, input rd_addr, output rd_data, output rd_hit);
endinterface

// Valid/ready item transfer
interface issue_if;
   logic                   valid;
   logic                   ready;
   fetch_pkg::fetch_item_t item;
   // Item is the halt instruction
   logic                   is_halt;

   modport source (output valid, input ready, output item, output is_halt);
   modport sink (input valid, output ready, input item, input is_halt);
endinterface

`default_nettype wire

//--- source/imem_apb.sv
////////////////////////////////////////////////////////////
// Instruction memory with APB load port
// APB read/write while idle, synchronous fetch read port
////////////////////////////////////////////////////////////
`default_nettype none
`include "fetch_settings.svh"

module imem_apb (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     run,
   input  wire                     psel,
   input  wire                     penable,
   input  wire                     pwrite,
   input  wire [`FETCH_WIDTH-1:0]  paddr,
   input  wire fetch_pkg::instr_t  pwdata,
   output fetch_pkg::instr_t       prdata,
   output logic                    pready,
   output logic                    pslverr,
   imem_rd_if.memory               rd
);

   // Word index width
   localparam int IDX_W = $clog2(`IMEM_DEPTH);

   fetch_pkg::instr_t mem [`IMEM_DEPTH];

   logic             apb_setup;
   logic             apb_access;
   logic             apb_err;
   logic [IDX_W-1:0] apb_idx;
   logic [IDX_W-1:0] fetch_idx;
   fetch_pkg::instr_t prdata_q;

   ////////////////////////////////////////////////////////////
   // APB decode
   ////////////////////////////////////////////////////////////

   assign apb_setup  = psel & ~penable;
   assign apb_access = psel & penable;

   // Out of range, or memory owned by fetch
   assign apb_err = (paddr >= `IMEM_DEPTH) | run;
   assign apb_idx = paddr[IDX_W-1:0];

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = apb_access & apb_err;

   // Zero on error or outside a read access
   assign prdata = (apb_access & ~pwrite & ~apb_err) ? prdata_q : '0;

   // Byte PC to word index, upper bits ignored
   assign fetch_idx = rd.rd_addr[IDX_W:1];

   ////////////////////////////////////////////////////////////
   // Memory array
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Write commits in the access cycle
      if (apb_access && pwrite && !apb_err) begin
         mem[apb_idx] <= pwdata;
      end
      // Read data fetched during setup
      if (apb_setup && !pwrite) begin
         prdata_q <= mem[apb_idx];
      end
      // Fetch port
      if (rd.rd_en) begin
         rd.rd_data <= mem[fetch_idx];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd.rd_hit <= 1'b0;
      end else begin
         rd.rd_hit <= rd.rd_en;
      end
   end

endmodule

`default_nettype wire

//--- source/raw_hazard_detector.sv
////////////////////////////////////////////////////////////
// Read-after-write hazard detector
// Per-register countdown of recently reported destinations
////////////////////////////////////////////////////////////
`default_nettype none
`include "fetch_settings.svh"

module raw_hazard_detector (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      dst_valid,
   input  wire fetch_pkg::reg_idx_t dst_reg,
   input  wire fetch_pkg::reg_idx_t src1,
   input  wire fetch_pkg::reg_idx_t src2,
   input  wire                      src1_used,
   input  wire                      src2_used,
   output logic                     raw
);

   localparam int NUM_REGS = 8;
   localparam int CNT_W    = $clog2(`HAZARD_WINDOW + 1);

   // Cycles left before each register is safe to read
   logic [CNT_W-1:0] pend_cnt [NUM_REGS];

   logic src1_busy;
   logic src2_busy;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            pend_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_REGS; i++) begin
            // New report restarts the window
            if (dst_valid && (dst_reg == fetch_pkg::reg_idx_t'(i))) begin
               pend_cnt[i] <= CNT_W'(`HAZARD_WINDOW);
            end else if (pend_cnt[i] != '0) begin
               pend_cnt[i] <= pend_cnt[i] - 1'b1;
            end
         end
      end
   end

   // Only real sources count
   assign src1_busy = src1_used & (pend_cnt[src1] != '0);
   assign src2_busy = src2_used & (pend_cnt[src2] != '0);

   assign raw = src1_busy | src2_busy;

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
////////////////////////////////////////////////////////////
// Instruction fetch stage
// PC, bubble insertion, jump hold and halt countdown
////////////////////////////////////////////////////////////
`default_nettype none
`include "fetch_settings.svh"

module fetch_stage (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      run,
   input  wire                      redirect_valid,
   input  wire fetch_pkg::pc_t      redirect_pc,
   input  wire                      dst_valid,
   input  wire fetch_pkg::reg_idx_t dst_reg,
   input  wire                      halt_out,
   output logic                     dump,
   imem_rd_if.master                rd,
   issue_if.source                  iss
);

   typedef enum logic [1:0] {st_idle, st_fetch, st_jump_wait, st_halted} state_t;

   localparam int HCNT_W = $clog2(`HALT_DELAY) + 1;

   state_t                 state_q, state_d;
   fetch_pkg::pc_t         pc_q, item_pc_q, fetch_addr;
   fetch_pkg::instr_t      instr;
   fetch_pkg::op_class_t   op_class;
   fetch_pkg::fetch_item_t item;
   logic                   held_q, hold_q, hold_bubble_q;
   logic                   avail, raw, bubble, xfer, take_real, fetch_go;
   logic                   rs_used, rt_used;
   logic                   halt_armed_q;
   logic [HCNT_W-1:0]      halt_cnt_q;

   // Memory output register keeps the instruction until next read
   assign instr   = rd.rd_data;
   assign avail   = rd.rd_hit | held_q;
   assign rs_used = fetch_pkg::uses_rs(instr[15:11]);
   assign rt_used = fetch_pkg::uses_rt(instr[15:11]);

   raw_hazard_detector raw_hazard_detector_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .dst_valid (dst_valid),
      .dst_reg   (dst_reg),
      .src1      (instr[10:8]),
      .src2      (instr[7:5]),
      .src1_used (rs_used),
      .src2_used (rt_used),
      .raw       (raw)
   );

   always_comb begin
      if (instr[15:11] == 5'b00000) begin
         op_class = fetch_pkg::op_halt;
      end else if ((instr[15:13] == 3'b001) || (instr[15:13] == 3'b011)) begin
         op_class = fetch_pkg::op_jump;
      end else begin
         op_class = fetch_pkg::op_other;
      end
   end

   ////////////////////////////////////////////////////////////
   // Issue side
   ////////////////////////////////////////////////////////////

   // An offered but stalled item keeps its kind
   assign bubble       = hold_q ? hold_bubble_q : raw;
   assign item.instr   = bubble ? `NOP_WORD : instr;
   assign item.incr_pc = item_pc_q + 16'd2;

   assign iss.valid   = (state_q == st_fetch) & avail;
   assign iss.item    = item;
   assign iss.is_halt = ~bubble & (op_class == fetch_pkg::op_halt);

   assign xfer      = iss.valid & iss.ready;
   assign take_real = xfer & ~bubble;

   ////////////////////////////////////////////////////////////
   // Fetch control
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_d    = state_q;
      fetch_go   = 1'b0;
      fetch_addr = pc_q;
      case (state_q)
         st_idle: begin
            // Program always starts at 0
            if (run) begin
               fetch_go   = 1'b1;
               fetch_addr = '0;
               state_d    = st_fetch;
            end
         end
         st_fetch: begin
            if (take_real && (op_class == fetch_pkg::op_jump)) begin
               state_d = st_jump_wait;
            end else if (take_real && (op_class == fetch_pkg::op_halt)) begin
               state_d = st_halted;
            end else if (run && (!avail || take_real)) begin
               fetch_go = 1'b1;
            end
         end
         st_jump_wait: begin
            // Target read straight away
            if (redirect_valid) begin
               fetch_go   = 1'b1;
               fetch_addr = redirect_pc;
               state_d    = st_fetch;
            end
         end
         default: begin
            // Halted until reset
         end
      endcase
   end

   assign rd.rd_en   = fetch_go;
   assign rd.rd_addr = fetch_addr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q       <= st_idle;
         pc_q          <= '0;
         held_q        <= 1'b0;
         hold_q        <= 1'b0;
         hold_bubble_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (fetch_go) begin
            pc_q <= fetch_addr + 16'd2;
         end
         // Instruction stays until really taken
         held_q        <= avail & ~take_real;
         hold_q        <= iss.valid & ~iss.ready;
         hold_bubble_q <= bubble;
      end
   end

   // PC of the word in the memory output register
   always_ff @(posedge clk) begin
      if (fetch_go) begin
         item_pc_q <= fetch_addr;
      end
   end

   ////////////////////////////////////////////////////////////
   // Halt countdown
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halt_armed_q <= 1'b0;
         halt_cnt_q   <= '0;
      end else if (halt_out && !halt_armed_q) begin
         halt_armed_q <= 1'b1;
         halt_cnt_q   <= HCNT_W'(`HALT_DELAY - 1);
      end else if (halt_armed_q && (halt_cnt_q != '0)) begin
         halt_cnt_q <= halt_cnt_q - 1'b1;
      end
   end

   // Sticky once the count runs out
   assign dump = halt_armed_q & (halt_cnt_q == '0);

endmodule

`default_nettype wire

//--- source/issue_buffer.sv
////////////////////////////////////////////////////////////
// Issue buffer
// One-entry register slice toward the downstream stage
////////////////////////////////////////////////////////////
`default_nettype none

module issue_buffer (
   input  wire               clk,
   input  wire               rst_n,
   input  wire               issue_ready,
   output logic              issue_valid,
   output fetch_pkg::instr_t issue_instr,
   output fetch_pkg::pc_t    issue_incr_pc,
   output logic              halt_out,
   issue_if.sink             iss
);

   logic                   full_q;
   logic                   halt_q;
   logic                   load;
   fetch_pkg::fetch_item_t item_q;

   // Refill in the same cycle the entry drains
   assign iss.ready = ~full_q | issue_ready;
   assign load      = iss.valid & iss.ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_q <= 1'b0;
         halt_q <= 1'b0;
      end else if (load) begin
         full_q <= 1'b1;
         halt_q <= iss.is_halt;
      end else if (issue_ready) begin
         full_q <= 1'b0;
         halt_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         item_q <= iss.item;
      end
   end

   assign issue_valid   = full_q;
   assign issue_instr   = item_q.instr;
   assign issue_incr_pc = item_q.incr_pc;

   // Halt leaving on the top ports
   assign halt_out = full_q & issue_ready & halt_q;

endmodule

`default_nettype wire

//--- source/fetch_unit_top.sv
////////////////////////////////////////////////////////////
// Fetch unit top level
// APB loaded memory, fetch stage and issue buffer
////////////////////////////////////////////////////////////
`default_nettype none
`include "fetch_settings.svh"

module fetch_unit_top (
   input  wire                      clk,
   input  wire                      rst_n,
   // APB load port
   input  wire                      psel,
   input  wire                      penable,
   input  wire                      pwrite,
   input  wire [`FETCH_WIDTH-1:0]   paddr,
   input  wire fetch_pkg::instr_t   pwdata,
   output wire fetch_pkg::instr_t   prdata,
   output wire                      pready,
   output wire                      pslverr,
   // Core control
   input  wire                      run,
   input  wire                      redirect_valid,
   input  wire fetch_pkg::pc_t      redirect_pc,
   input  wire                      dst_valid,
   input  wire fetch_pkg::reg_idx_t dst_reg,
   // Issue port
   output wire                      issue_valid,
   input  wire                      issue_ready,
   output wire fetch_pkg::instr_t   issue_instr,
   output wire fetch_pkg::pc_t      issue_incr_pc,
   output wire                      dump
);

   logic halt_out;

   imem_rd_if imem_rd ();
   issue_if   issue ();

   imem_apb imem_apb_inst (
      .clk (clk), .rst_n (rst_n), .run (run),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
      .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
      .rd (imem_rd.memory)
   );

   fetch_stage fetch_stage_inst (
      .clk (clk), .rst_n (rst_n), .run (run),
      .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
      .dst_valid (dst_valid), .dst_reg (dst_reg),
      .halt_out (halt_out), .dump (dump),
      .rd (imem_rd.master), .iss (issue.source)
   );

   issue_buffer issue_buffer_inst (
      .clk (clk), .rst_n (rst_n), .issue_ready (issue_ready),
      .issue_valid (issue_valid), .issue_instr (issue_instr),
      .issue_incr_pc (issue_incr_pc), .halt_out (halt_out),
      .iss (issue.sink)
   );

endmodule

`default_nettype wire

//--- tb/fetch_tb_clock.sv
////////////////////////////////////////////////////////////
// Testbench clock generator
////////////////////////////////////////////////////////////
`default_nettype none

module fetch_tb_clock #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial clk = 1'b0;

   // Free running, starts low
   always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb/fetch_tb.sv
////////////////////////////////////////////////////////////
// Fetch unit testbench
// APB load, hazard bubbles, jump, back-pressure and halt
////////////////////////////////////////////////////////////
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb;

   localparam logic [15:0] JUMP_TARGET = 16'h0040;
   localparam int          PROG_WORDS  = 40;
   // Two loads and two runs take well under 1000 cycles
   localparam int          CYCLE_LIMIT = 4000;

   logic        clk;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [15:0] paddr;
   logic [15:0] pwdata;
   logic [15:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        run;
   logic        redirect_valid = 1'b0;
   logic [15:0] redirect_pc    = '0;
   logic        dst_valid      = 1'b0;
   logic [2:0]  dst_reg        = '0;
   logic        issue_ready    = 1'b1;
   logic        issue_valid;
   logic [15:0] issue_instr;
   logic [15:0] issue_incr_pc;
   logic        dump;

   // Stimulus control
   logic        hazard_mode;
   logic        random_ready;
   logic [31:0] rand_state = 32'h6995_79aa;
   logic [15:0] prog [PROG_WORDS];

   // Reference model state
   logic [15:0] exp_instr [$];
   logic [15:0] exp_pc [$];
   int          cnt_model [8];
   int          cnt_last [8];
   logic        jump_wait = 1'b0;
   logic        halt_seen;
   int          since_halt;
   int          cycle_count = 0;
   logic [15:0] rd_word;
   logic        rd_err;

   fetch_tb_clock #(.PERIOD(8)) fetch_tb_clock_inst (.clk(clk));

   fetch_unit_top fetch_unit_top_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .run            (run),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .dst_valid      (dst_valid),
      .dst_reg        (dst_reg),
      .issue_valid    (issue_valid),
      .issue_ready    (issue_ready),
      .issue_instr    (issue_instr),
      .issue_incr_pc  (issue_incr_pc),
      .dump           (dump)
   );

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic fail_value(input string test, input logic [15:0] exp, input logic [15:0] act);
      fail_stop($sformatf("FAIL %s expected %h actual %h", test, exp, act));
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [15:0] make_instr(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [2:0] rt, input int low);
      return {op, rs, rt, low[4:0]};
   endfunction

   // Operand rules by opcode
   function automatic logic rs_read(input logic [4:0] op);
      return (op[4:2] != 3'b000) && !((op[4:2] == 3'b001) && (op[0] == 1'b0));
   endfunction

   function automatic logic rt_read(input logic [4:0] op);
      return (op[4:1] == 4'b1101) || (op[4:2] == 3'b111);
   endfunction

   function automatic logic is_jump_word(input logic [15:0] w);
      return (w[15:13] == 3'b001) || (w[15:13] == 3'b011);
   endfunction

   // Pending operand in the cycle the word was offered
   function automatic logic source_busy(input logic [15:0] w);
      return (rs_read(w[15:11]) && cnt_last[w[10:8]] != 0) ||
             (rt_read(w[15:11]) && cnt_last[w[7:5]] != 0);
   endfunction

   task automatic build_program();
      for (int i = 0; i < PROG_WORDS; i++) begin
         // Filler never fetched
         prog[i] = {5'b10010, 11'(i * 37 + 5)};
      end
      prog[0]  = make_instr(5'b10000, 1, 2, 0);
      prog[1]  = make_instr(5'b11010, 3, 4, 1);
      prog[2]  = make_instr(5'b00010, 1, 1, 2);
      prog[3]  = make_instr(5'b01000, 5, 1, 3);
      prog[4]  = make_instr(5'b11100, 6, 7, 4);
      prog[5]  = make_instr(5'b10000, 2, 3, 5);
      prog[6]  = make_instr(5'b11010, 7, 5, 6);
      // Jump whose rs is read
      prog[7]  = make_instr(5'b00101, 3, 0, 7);
      prog[32] = make_instr(5'b01000, 1, 2, 8);
      prog[33] = make_instr(5'b11100, 3, 5, 9);
      prog[34] = make_instr(5'b00010, 4, 6, 10);
      prog[35] = make_instr(5'b10000, 7, 0, 11);
      prog[36] = make_instr(5'b11010, 2, 6, 12);
      prog[37] = make_instr(5'b01000, 4, 3, 13);
      prog[38] = 16'h0000;
   endtask

   task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                             output logic [15:0] rdata, output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      if (pready !== 1'b1) begin
         fail_stop("APB transfer did not complete in its access cycle");
      end
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   ////////////////////////////////////////////////////////////
   // Drivers, monitor and assertions
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      #1;
      rand_state     = lcg_next(rand_state);
      issue_ready    = random_ready ? (rand_state[18:17] != 2'b00) : 1'b1;
      dst_valid      = hazard_mode && run && (rand_state[22:21] == 2'b00);
      dst_reg        = rand_state[26:24];
      // Jump target after a random wait
      redirect_valid = jump_wait && (rand_state[29:28] == 2'b00);
      redirect_pc    = JUMP_TARGET;
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         exp_instr.delete();
         exp_pc.delete();
         for (int i = 0; i < PROG_WORDS; i++) begin
            if ((i < 8) || ((i >= 32) && (i <= 38))) begin
               exp_instr.push_back(prog[i]);
               exp_pc.push_back(16'(2 * i + 2));
            end
         end
         for (int r = 0; r < 8; r++) begin
            cnt_model[r] = 0;
            cnt_last[r]  = 0;
         end
         jump_wait  = 1'b0;
         halt_seen  = 1'b0;
         since_halt = 0;
      end else begin
         if (halt_seen) begin
            since_halt++;
         end
         if (dump !== (halt_seen && (since_halt >= `HALT_DELAY))) begin
            fail_value("halt_dump", 16'(halt_seen && (since_halt >= `HALT_DELAY)), 16'(dump));
         end
         if (issue_valid && issue_ready) begin
            if (halt_seen) begin
               fail_stop("instruction issued after the halt");
            end else if (issue_instr == `NOP_WORD) begin
               if ((exp_instr.size() == 0) || !source_busy(exp_instr[0])) begin
                  fail_stop("bubble issued without a pending operand");
               end
            end else if (jump_wait) begin
               fail_stop("instruction issued before the jump redirect");
            end else if (exp_instr.size() == 0) begin
               fail_stop("more instructions issued than the program holds");
            end else if (issue_instr !== exp_instr[0]) begin
               fail_value("fetch_order", exp_instr[0], issue_instr);
            end else if (issue_incr_pc !== exp_pc[0]) begin
               fail_value("incr_pc", exp_pc[0], issue_incr_pc);
            end else if (source_busy(issue_instr)) begin
               fail_stop("instruction issued over a pending operand");
            end else begin
               void'(exp_instr.pop_front());
               void'(exp_pc.pop_front());
               if (issue_instr == 16'h0000) begin
                  halt_seen  = 1'b1;
                  since_halt = 0;
               end
               if (is_jump_word(issue_instr)) begin
                  jump_wait = 1'b1;
               end
            end
         end
         if (redirect_valid) begin
            jump_wait = 1'b0;
         end
         // Scoreboard model, one window per report
         for (int r = 0; r < 8; r++) begin
            cnt_last[r] = cnt_model[r];
            if (dst_valid && (dst_reg == 3'(r))) begin
               cnt_model[r] = `HAZARD_WINDOW;
            end else if (cnt_model[r] != 0) begin
               cnt_model[r] = cnt_model[r] - 1;
            end
         end
      end
   end

   // Stalled output holds still
   assert property (@(posedge clk) disable iff (!rst_n)
      (issue_valid && !issue_ready) |=> ($stable(issue_instr) && $stable(issue_incr_pc)))
      else fail_stop("issue output changed while stalled");

   // dump is sticky
   assert property (@(posedge clk) disable iff (!rst_n) dump |=> dump)
      else fail_stop("dump dropped after rising");

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         fail_stop("timeout, the run did not finish within the cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n        = 1'b0;
      run          = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      hazard_mode  = 1'b1;
      random_ready = 1'b0;
      build_program();
      apply_reset();

      // Load and read back
      for (int i = 0; i < PROG_WORDS; i++) begin
         apb_access(1'b1, 16'(i), prog[i], rd_word, rd_err);
         if (rd_err) begin
            fail_stop("APB write to a valid address flagged an error");
         end
      end
      for (int i = 0; i < PROG_WORDS; i++) begin
         apb_access(1'b0, 16'(i), '0, rd_word, rd_err);
         if (rd_err || (rd_word !== prog[i])) begin
            fail_value("apb_readback", prog[i], rd_word);
         end
      end
      // Out of range, index aliases word 0
      apb_access(1'b1, 16'(`IMEM_DEPTH), 16'hdead, rd_word, rd_err);
      if (!rd_err) begin
         fail_stop("APB write beyond memory gave no error");
      end
      apb_access(1'b0, 16'd300, '0, rd_word, rd_err);
      if (!rd_err || (rd_word !== '0)) begin
         fail_value("apb_range_read", 16'h0000, rd_word);
      end
      apb_access(1'b0, 16'd0, '0, rd_word, rd_err);
      if (rd_word !== prog[0]) begin
         fail_value("apb_alias_write", prog[0], rd_word);
      end

      // Hazard run with ready held high
      @(posedge clk);
      #1;
      run = 1'b1;
      apb_access(1'b1, 16'd5, 16'hffff, rd_word, rd_err);
      if (!rd_err) begin
         fail_stop("APB write while running gave no error");
      end
      apb_access(1'b0, 16'd5, '0, rd_word, rd_err);
      if (!rd_err || (rd_word !== '0)) begin
         fail_value("apb_run_read", 16'h0000, rd_word);
      end
      while (dump !== 1'b1) @(posedge clk);
      repeat (8) @(posedge clk);
      if (exp_instr.size() != 0) begin
         fail_stop("hazard run ended before the whole program issued");
      end

      // Back-pressure run
      @(posedge clk);
      #1;
      run          = 1'b0;
      hazard_mode  = 1'b0;
      random_ready = 1'b1;
      apply_reset();
      @(posedge clk);
      #1;
      run = 1'b1;
      while (dump !== 1'b1) @(posedge clk);
      repeat (8) @(posedge clk);

      if (exp_instr.size() != 0) begin
         fail_stop("back-pressure run ended before the whole program issued");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/fetch_pkg.sv
source/fetch_if.sv
source/imem_apb.sv
source/raw_hazard_detector.sv
source/fetch_stage.sv
source/issue_buffer.sv
source/fetch_unit_top.sv
tb/fetch_tb_clock.sv
tb/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
SIM        := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
